// File: build.f
aes_pkg.sv
aes_dec_ctrl.sv
aes_key_sched.sv
aes_inv_sub_bytes.sv
aes_inv_mix_cols.sv
aes_round_state.sv
aes_inv_cipher_top.sv
aes_inv_cipher_properties.sv
tb_aes_inv_cipher.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the AES decryption testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_aes_inv_cipher -f build.f -o sim_aes \
  && ./obj_dir/sim_aes > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation completed successfully" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

// File: tb_aes_inv_cipher.sv
// Testbench for the AES-128 decryption core
// Own S-box tables and key expansion form the reference model
// Results checked on every done
module tb_aes_inv_cipher;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_CYCLES = 8*80 + 24*250;  // Key loads plus blocks

  logic clk, rstn, kld, ld, kdone, done;
  logic [127:0] key, text_in, text_out;

  logic [7:0]   sbox_t [256];
  logic [7:0]   inv_sbox_t [256];
  logic [127:0] exp_q [$];   // Expected plaintext per accepted ld
  string        name_q [$];
  logic [127:0] exp_pt;
  logic [127:0] ct;
  string        nm;
  int seed = 0;
  int errors = 0;
  int tests = 0;
  int cycle_cnt = 0;
  int done_cnt = 0;
  int kdone_cnt = 0;
  int blocks_sent = 0;
  int keys_sent = 0;

  aes_inv_cipher_top dut_i (
    .clk(clk), .rstn(rstn), .kld(kld), .ld(ld), .key(key), .text_in(text_in),
    .kdone(kdone), .done(done), .text_out(text_out)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  //////////////////////////////
  // Reference model

  function automatic logic [7:0] gmul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    p = 8'h00;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) p = p ^ a;
      a = {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    end
    return p;
  endfunction

  // Brute-force inverse then affine map
  task automatic build_tables();
    logic [7:0] inv;
    logic [7:0] b;
    for (int a = 0; a < 256; a++) begin
      inv = 8'h00;
      for (int c = 1; c < 256; c++) begin
        if (gmul(8'(a), 8'(c)) == 8'h01) inv = 8'(c);
      end
      b = inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]}
          ^ {inv[3:0], inv[7:4]} ^ 8'h63;
      sbox_t[a]     = b;
      inv_sbox_t[b] = 8'(a);
    end
  endtask

  function automatic logic [127:0] aes128_decrypt(input logic [127:0] k,
                                                   input logic [127:0] c_in);
    logic [31:0]  w [44];
    logic [7:0]   s [16];
    logic [7:0]   t [16];
    logic [31:0]  tmp;
    logic [7:0]   rc;
    logic [127:0] res;
    rc = 8'h01;
    for (int i = 0; i < 4; i++) w[i] = k[127-32*i -: 32];
    for (int i = 4; i < 44; i++) begin
      tmp = w[i-1];
      if (i % 4 == 0) begin  // RotWord, SubWord, Rcon
        tmp = {sbox_t[tmp[23:16]], sbox_t[tmp[15:8]], sbox_t[tmp[7:0]], sbox_t[tmp[31:24]]}
              ^ {rc, 24'h000000};
        rc = gmul(rc, 8'h02);
      end
      w[i] = w[i-4] ^ tmp;
    end
    for (int i = 0; i < 16; i++) s[i] = c_in[127-8*i -: 8] ^ w[40 + i/4][31-8*(i%4) -: 8];
    for (int r = 9; r >= 0; r--) begin
      for (int c = 0; c < 4; c++) begin
        for (int j = 0; j < 4; j++) begin
          t[((c+j)%4)*4 + j] = inv_sbox_t[s[c*4+j]];  // Row j moves right by j
        end
      end
      for (int i = 0; i < 16; i++) t[i] = t[i] ^ w[4*r + i/4][31-8*(i%4) -: 8];
      for (int c = 0; c < 4; c++) begin
        for (int j = 0; j < 4; j++) begin
          if (r > 0) begin  // No mix in the last round
            s[c*4+j] = gmul(t[c*4+j], 8'h0e) ^ gmul(t[c*4+(j+1)%4], 8'h0b)
                       ^ gmul(t[c*4+(j+2)%4], 8'h0d) ^ gmul(t[c*4+(j+3)%4], 8'h09);
          end else begin
            s[c*4+j] = t[c*4+j];
          end
        end
      end
    end
    for (int i = 0; i < 16; i++) res[127-8*i -: 8] = s[i];
    return res;
  endfunction

  function automatic logic [127:0] rand128();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  //////////////////////////////
  // Stimulus helpers

  task automatic pulse_ld(input logic [127:0] c_in);
    @(posedge clk);
    #1;
    text_in = c_in;
    ld      = 1'b1;
    @(posedge clk);
    #1;
    ld = 1'b0;
  endtask

  task automatic send_block(input logic [127:0] c_in, input string name);
    exp_q.push_back(aes128_decrypt(key, c_in));  // key input still holds
    name_q.push_back(name);
    blocks_sent++;
    pulse_ld(c_in);
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (done_cnt < blocks_sent && n < 300) begin
      @(posedge clk);
      n++;
    end
    if (done_cnt < blocks_sent) begin
      $display("No done within 300 cycles of ld");
      errors++;
    end
  endtask

  task automatic load_key(input logic [127:0] k);
    int n;
    n = 0;
    keys_sent++;
    @(posedge clk);
    #1;
    key = k;
    kld = 1'b1;
    @(posedge clk);
    #1;
    kld = 1'b0;
    while (kdone_cnt < keys_sent && n < 80) begin
      @(posedge clk);
      n++;
    end
    if (kdone_cnt < keys_sent) begin
      $display("No kdone within 80 cycles of kld");
      errors++;
    end
  endtask

  //////////////////////////////
  // Compare on done at the falling edge

  always @(negedge clk) begin
    if (kdone) kdone_cnt++;
    if (done) begin
      done_cnt++;
      if (exp_q.size() == 0) begin
        $display("Unexpected done with no block outstanding at cycle %0d", cycle_cnt);
        errors++;
      end else begin
        exp_pt = exp_q.pop_front();
        nm     = name_q.pop_front();
        tests++;
        if (text_out !== exp_pt) begin
          $display("Fail %s expected %h actual %h", nm, exp_pt, text_out);
          errors++;
        end else begin
          $display("Pass %s %h", nm, text_out);
        end
      end
    end
  end

  // Hard stop
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, done or kdone never came", cycle_cnt);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////
  // Test sequence

  initial begin
    rstn    = 1'b0;
    kld     = 1'b0;
    ld      = 1'b0;
    key     = '0;
    text_in = '0;
    seed    = 32'hdaf6;
    build_tables();
    repeat (5) @(posedge clk);
    #1;
    kld     = 1'b1;  // Load requests while reset is held
    ld      = 1'b1;
    key     = rand128();
    text_in = rand128();
    @(posedge clk);
    #1;
    kld = 1'b0;
    ld  = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rstn = 1'b1;

    // Test 1 ld without a key does nothing
    pulse_ld(rand128());
    repeat (250) @(posedge clk);
    tests++;
    if (done_cnt != 0 || kdone_cnt != 0) begin
      $display("Fail reset_no_key, done or kdone rose before any key load");
      errors++;
    end else begin
      $display("Pass reset_no_key");
    end

    // Test 2 FIPS-197 vector
    load_key(128'h000102030405060708090a0b0c0d0e0f);
    ct = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    if (aes128_decrypt(key, ct) !== 128'h00112233445566778899aabbccddeeff) begin
      $display("Fail fips_reference expected %h actual %h",
               128'h00112233445566778899aabbccddeeff, aes128_decrypt(key, ct));
      errors++;
    end
    send_block(ct, "fips_vector");
    wait_done();

    // Test 3 same key for eight blocks in a row
    for (int i = 0; i < 8; i++) begin
      send_block(rand128(), $sformatf("same_key_%0d", i));
      wait_done();
    end

    // Test 4 key changes between blocks
    for (int k = 0; k < 6; k++) begin
      load_key(rand128());
      for (int b = 0; b < 2; b++) begin
        send_block(rand128(), $sformatf("key%0d_blk%0d", k, b));
        wait_done();
      end
    end

    // Test 5 second ld mid-block is dropped
    send_block(rand128(), "ignore_second_ld");
    repeat (50) @(posedge clk);
    pulse_ld(rand128());
    wait_done();
    repeat (250) @(posedge clk);
    tests++;
    if (done_cnt != blocks_sent) begin
      $display("Fail no_extra_done expected %0d actual %0d", blocks_sent, done_cnt);
      errors++;
    end else begin
      $display("Pass no_extra_done");
    end

    $display("Tests %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: aes_inv_cipher_properties.sv
// Controller checks, bound into aes_dec_ctrl
// Pulse width, pulse overlap and enable exclusivity
module aes_inv_cipher_properties (
  input logic clk,
  input logic rstn,
  input logic kdone,
  input logic done,
  input logic key_load,
  input logic key_sub_en,
  input logic key_write,
  input logic load_en,
  input logic sub_en,
  input logic mix_en,
  input logic state_en,
  input logic out_en
);
  timeunit 1ns;
  timeprecision 100ps;

  logic any_en;

  assign any_en = key_load | key_sub_en | key_write | load_en | sub_en | mix_en
                  | state_en | out_en;

  kdone_pulse: assert property (@(posedge clk) disable iff (!rstn) kdone |=> !kdone)
    else $error("kdone high for more than one cycle");
  done_pulse: assert property (@(posedge clk) disable iff (!rstn) done |=> !done)
    else $error("done high for more than one cycle");
  no_overlap: assert property (@(posedge clk) disable iff (!rstn) !(done && kdone))
    else $error("done and kdone high together");
  state_write_excl: assert property (@(posedge clk) disable iff (!rstn)
    $onehot0({load_en, state_en, out_en}))
    else $error("More than one state register enable");
  quiet_in_reset: assert property (@(posedge clk) !rstn |-> !any_en)  // All enables off
    else $error("Enable high during reset");

endmodule

bind aes_dec_ctrl aes_inv_cipher_properties props_i (
  .clk(clk), .rstn(rstn), .kdone(kdone), .done(done),
  .key_load(key_load), .key_sub_en(key_sub_en), .key_write(key_write),
  .load_en(load_en), .sub_en(sub_en), .mix_en(mix_en),
  .state_en(state_en), .out_en(out_en)
);

// File: aes_inv_cipher_top.sv
// AES-128 decryption core, area reduced
// Key expanded once into a buffer, then blocks decrypted byte-serially
module aes_inv_cipher_top (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        kld,
  input  logic                        ld,
  input  logic [aes_pkg::BLOCK_W-1:0] key,
  input  logic [aes_pkg::BLOCK_W-1:0] text_in,
  output logic                        kdone,
  output logic                        done,
  output logic [aes_pkg::BLOCK_W-1:0] text_out
);

  // Control to datapath
  logic key_load, key_sub_en, key_write;
  logic load_en, sub_en, mix_en, state_en, out_en;
  logic [1:0] key_byte_sel;
  logic [1:0] col_sel;
  logic [3:0] byte_sel;
  logic [aes_pkg::ROUND_W-1:0] round_idx;

  // Datapath blocks
  aes_pkg::aes_block_u round_key;
  aes_pkg::aes_block_u shift_state;
  aes_pkg::aes_block_u sub_state;
  aes_pkg::aes_block_u ark_state;
  aes_pkg::aes_block_u mix_state;

  aes_dec_ctrl u_ctrl (
    .clk(clk), .rstn(rstn), .kld(kld), .ld(ld),
    .kdone(kdone), .done(done),
    .key_load(key_load), .key_sub_en(key_sub_en), .key_write(key_write),
    .load_en(load_en), .sub_en(sub_en), .mix_en(mix_en),
    .state_en(state_en), .out_en(out_en),
    .key_byte_sel(key_byte_sel), .col_sel(col_sel), .byte_sel(byte_sel),
    .round_idx(round_idx)
  );

  aes_key_sched u_key (
    .clk(clk), .key_load(key_load), .key_sub_en(key_sub_en), .key_write(key_write),
    .key_byte_sel(key_byte_sel), .round_idx(round_idx), .key(key),
    .round_key(round_key)
  );

  aes_inv_sub_bytes u_sub (
    .clk(clk), .sub_en(sub_en), .byte_sel(byte_sel),
    .shift_state(shift_state), .sub_state(sub_state)
  );

  aes_inv_mix_cols u_mix (
    .clk(clk), .mix_en(mix_en), .col_sel(col_sel),
    .ark_state(ark_state), .mix_state(mix_state)
  );

  aes_round_state u_state (
    .clk(clk), .load_en(load_en), .state_en(state_en), .out_en(out_en),
    .text_in(text_in), .round_key(round_key),
    .sub_state(sub_state), .mix_state(mix_state),
    .shift_state(shift_state), .ark_state(ark_state),
    .text_out(text_out)
  );

endmodule

// File: aes_round_state.sv
// Decryption state register and output register
// Inverse ShiftRows and AddRoundKey are plain wiring and XOR here
module aes_round_state (
  input  logic                        clk,
  input  logic                        load_en,
  input  logic                        state_en,
  input  logic                        out_en,
  input  logic [aes_pkg::BLOCK_W-1:0] text_in,
  input  aes_pkg::aes_block_u         round_key,
  input  aes_pkg::aes_block_u         sub_state,
  input  aes_pkg::aes_block_u         mix_state,
  output aes_pkg::aes_block_u         shift_state,
  output aes_pkg::aes_block_u         ark_state,
  output logic [aes_pkg::BLOCK_W-1:0] text_out
);

  aes_pkg::aes_block_u st;  // Round state

  //////////////////////////////
  // State update

  always_ff @(posedge clk) begin
    if (load_en) begin
      st.bytes <= text_in ^ round_key.bytes;  // Initial AddRoundKey with k10
    end else if (state_en) begin
      st <= mix_state;
    end
  end

  // Inverse ShiftRows
  // Row r rotates right by r columns
  always_comb begin
    for (int c = 0; c < aes_pkg::NUM_COLS; c++) begin
      for (int r = 0; r < 4; r++) begin
        shift_state.bytes[c*4 + r] = st.bytes[((c + 4 - r) % 4)*4 + r];
      end
    end
  end

  assign ark_state.bytes = sub_state.bytes ^ round_key.bytes;

  //////////////////////////////
  // Plaintext out

  always_ff @(posedge clk) begin
    if (out_en) begin
      text_out <= ark_state.bytes;  // Holds until next block finishes
    end
  end

endmodule

// File: aes_inv_mix_cols.sv
// Inverse MixColumns with one shared column unit
// One column per cycle into a 4-column result array
module aes_inv_mix_cols (
  input  logic                clk,
  input  logic                mix_en,
  input  logic [1:0]          col_sel,
  input  aes_pkg::aes_block_u ark_state,
  output aes_pkg::aes_block_u mix_state
);

  logic [31:0] mix_arr [aes_pkg::NUM_COLS];
  logic [31:0] sel_col;

  assign sel_col = ark_state.cols[col_sel];  // After AddRoundKey

  always_ff @(posedge clk) begin
    if (mix_en) begin
      mix_arr[col_sel] <= aes_pkg::inv_mix_col(sel_col);
    end
  end

  // Array back to a block
  always_comb begin
    for (int c = 0; c < aes_pkg::NUM_COLS; c++) begin
      mix_state.cols[c] = mix_arr[c];
    end
  end

endmodule

// File: aes_inv_sub_bytes.sv
// Inverse SubBytes with one shared inverse S-box
// One byte per cycle into a 16-byte result array
module aes_inv_sub_bytes (
  input  logic                clk,
  input  logic                sub_en,
  input  logic [3:0]          byte_sel,
  input  aes_pkg::aes_block_u shift_state,
  output aes_pkg::aes_block_u sub_state
);

  logic [7:0] sub_arr [aes_pkg::NUM_BYTES];
  logic [7:0] sel_byte;

  assign sel_byte = shift_state.bytes[byte_sel];  // Already inverse-shifted

  always_ff @(posedge clk) begin
    if (sub_en) begin
      sub_arr[byte_sel] <= aes_pkg::inv_sbox(sel_byte);
    end
  end

  // Array back to a block
  always_comb begin
    for (int i = 0; i < aes_pkg::NUM_BYTES; i++) begin
      sub_state.bytes[i] = sub_arr[i];
    end
  end

endmodule

// File: aes_key_sched.sv
// AES-128 key expansion, one sbox byte per cycle
// Round keys 0..10 kept in a buffer, read back by round index
module aes_key_sched (
  input  logic                        clk,
  input  logic                        key_load,
  input  logic                        key_sub_en,
  input  logic                        key_write,
  input  logic [1:0]                  key_byte_sel,
  input  logic [aes_pkg::ROUND_W-1:0] round_idx,
  input  logic [aes_pkg::BLOCK_W-1:0] key,
  output aes_pkg::aes_block_u         round_key
);

  aes_pkg::aes_block_u work_key;                       // Latest round key
  aes_pkg::aes_block_u next_key;
  aes_pkg::aes_block_u key_buf [0:aes_pkg::NUM_ROUNDS];
  logic [0:3][7:0]     rot_word;                       // RotWord of last column
  logic [0:3][7:0]     sub_word;                       // SubWord result, filled serially
  logic [31:0]         temp;

  assign rot_word = {work_key.cols[3][23:0], work_key.cols[3][31:24]};

  //////////////////////////////
  // Next round key

  always_comb begin
    temp             = sub_word ^ {aes_pkg::rcon(round_idx), 24'h000000};
    next_key.cols[0] = work_key.cols[0] ^ temp;
    next_key.cols[1] = work_key.cols[1] ^ next_key.cols[0];
    next_key.cols[2] = work_key.cols[2] ^ next_key.cols[1];
    next_key.cols[3] = work_key.cols[3] ^ next_key.cols[2];
  end

  // Shared forward sbox
  always_ff @(posedge clk) begin
    if (key_sub_en) begin
      sub_word[key_byte_sel] <= aes_pkg::sbox(rot_word[key_byte_sel]);
    end
  end

  // Working key and buffer writes
  always_ff @(posedge clk) begin
    if (key_load) begin
      work_key   <= key;
      key_buf[0] <= key;  // Round 0 is the cipher key
    end else if (key_write) begin
      work_key           <= next_key;
      key_buf[round_idx] <= next_key;
    end
  end

  // Registered read
  // Forward the key being written so k10 is ready right at kdone
  always_ff @(posedge clk) begin
    if (key_write) begin
      round_key <= next_key;
    end else begin
      round_key <= key_buf[round_idx];
    end
  end

endmodule

// File: aes_dec_ctrl.sv
// Sequencer for key expansion and decryption rounds
// Owns every enable, byte/column step and the round index
module aes_dec_ctrl (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        kld,
  input  logic                        ld,
  output logic                        kdone,
  output logic                        done,
  output logic                        key_load,
  output logic                        key_sub_en,
  output logic                        key_write,
  output logic                        load_en,
  output logic                        sub_en,
  output logic                        mix_en,
  output logic                        state_en,
  output logic                        out_en,
  output logic [1:0]                  key_byte_sel,
  output logic [1:0]                  col_sel,
  output logic [3:0]                  byte_sel,
  output logic [aes_pkg::ROUND_W-1:0] round_idx
);

  logic [2:0]                  state;
  logic [aes_pkg::ROUND_W-1:0] rnd;       // Counts up in expansion and down in decryption
  logic [3:0]                  byte_cnt;
  logic [1:0]                  col_cnt;
  logic                        key_ok;    // Not busy so a new key is allowed
  logic                        last_upd;

  // No key load while reset is held
  assign key_ok   = rstn && ((state == aes_pkg::IDLE) || (state == aes_pkg::KEY_READY));
  assign key_load = kld && key_ok;
  assign load_en  = ld && !kld && (state == aes_pkg::KEY_READY);  // kld wins

  assign key_sub_en = (state == aes_pkg::KEY_SUB);
  assign key_write  = (state == aes_pkg::KEY_WRITE);
  assign sub_en     = (state == aes_pkg::DEC_SUB);
  assign mix_en     = (state == aes_pkg::DEC_MIX);

  // rnd has moved on by update time and is back at 10 after round 0
  assign last_upd = (state == aes_pkg::DEC_UPDATE) && (rnd == aes_pkg::NUM_ROUNDS);
  assign state_en = (state == aes_pkg::DEC_UPDATE) && !last_upd;
  assign out_en   = last_upd;

  assign key_byte_sel = byte_cnt[1:0];
  assign byte_sel     = byte_cnt;
  assign col_sel      = col_cnt;
  assign round_idx    = rnd;  // Also the key buffer read address

  //////////////////////////////
  // State machine

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state    <= aes_pkg::IDLE;
      rnd      <= '0;
      byte_cnt <= '0;
      col_cnt  <= '0;
      kdone    <= 1'b0;
      done     <= 1'b0;
    end else begin
      kdone <= 1'b0;  // Pulses
      done  <= 1'b0;
      case (state)
        aes_pkg::IDLE, aes_pkg::KEY_READY: begin
          byte_cnt <= '0;
          if (key_load) begin
            rnd   <= 1;
            state <= aes_pkg::KEY_SUB;
          end else if (load_en) begin
            rnd   <= aes_pkg::NUM_ROUNDS - 1;  // ct ^ k10 loads now
            state <= aes_pkg::DEC_SUB;
          end
        end
        aes_pkg::KEY_SUB: begin
          if (byte_cnt == 4'd3) begin
            byte_cnt <= '0;
            state    <= aes_pkg::KEY_WRITE;
          end else begin
            byte_cnt <= byte_cnt + 1;
          end
        end
        aes_pkg::KEY_WRITE: begin
          if (rnd == aes_pkg::NUM_ROUNDS) begin
            kdone <= 1'b1;               // k10 lands this edge
            state <= aes_pkg::KEY_READY;  // rnd stays at 10 for the first load
          end else begin
            rnd   <= rnd + 1;
            state <= aes_pkg::KEY_SUB;
          end
        end
        aes_pkg::DEC_SUB: begin
          if (byte_cnt == 4'(aes_pkg::NUM_BYTES - 1)) begin
            byte_cnt <= '0;
            if (rnd == '0) begin
              rnd   <= aes_pkg::NUM_ROUNDS;  // Final round skips the mix
              state <= aes_pkg::DEC_UPDATE;
            end else begin
              col_cnt <= '0;
              state   <= aes_pkg::DEC_MIX;
            end
          end else begin
            byte_cnt <= byte_cnt + 1;
          end
        end
        aes_pkg::DEC_MIX: begin
          if (col_cnt == 2'(aes_pkg::NUM_COLS - 1)) begin
            col_cnt <= '0;
            rnd     <= rnd - 1;  // Next key read starts during update
            state   <= aes_pkg::DEC_UPDATE;
          end else begin
            col_cnt <= col_cnt + 1;
          end
        end
        aes_pkg::DEC_UPDATE: begin
          if (last_upd) begin
            done  <= 1'b1;  // Same cycle text_out changes
            state <= aes_pkg::KEY_READY;
          end else begin
            state <= aes_pkg::DEC_SUB;
          end
        end
        default: state <= aes_pkg::IDLE;
      endcase
    end
  end

endmodule

// File: aes_pkg.sv
// AES-128 shared definitions
// Block sizes, FSM state codes, the block union and GF(2^8) math
// S-box values come from field inversion and the affine map, not a table
package aes_pkg;

  localparam int BLOCK_W   = 128;
  localparam int NUM_BYTES = 16;
  localparam int NUM_COLS  = 4;
  localparam int ROUND_W   = 4;
  localparam logic [ROUND_W-1:0] NUM_ROUNDS = 4'd10;

  // Controller state codes
  localparam logic [2:0] IDLE       = 3'd0;
  localparam logic [2:0] KEY_SUB    = 3'd1;  // One key byte through sbox
  localparam logic [2:0] KEY_WRITE  = 3'd2;  // Round key into buffer
  localparam logic [2:0] KEY_READY  = 3'd3;
  localparam logic [2:0] DEC_SUB    = 3'd4;  // One state byte per cycle
  localparam logic [2:0] DEC_MIX    = 3'd5;  // One column per cycle
  localparam logic [2:0] DEC_UPDATE = 3'd6;

  // Same 128 bits seen as bytes or as columns
  // Byte index is col*4 + row, index 0 at the MSB end
  typedef union packed {
    logic [0:NUM_BYTES-1][7:0] bytes;
    logic [0:NUM_COLS-1][31:0] cols;
  } aes_block_u;

  //////////////////////////////
  // GF(2^8) arithmetic, poly 0x11b

  function automatic logic [7:0] xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (8'h1b & {8{b[7]}});
  endfunction

  // Shift-and-add multiply
  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] sh;
    acc = 8'h00;
    sh  = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) acc = acc ^ sh;
      sh = xtime(sh);
    end
    return acc;
  endfunction

  // a^254 by repeated squaring, 0 stays 0
  function automatic logic [7:0] gf_inv(input logic [7:0] a);
    logic [7:0] sq;
    logic [7:0] acc;
    sq  = a;
    acc = 8'h01;
    for (int i = 0; i < 7; i++) begin
      sq  = gf_mul(sq, sq);   // a^2, a^4 .. a^128
      acc = gf_mul(acc, sq);
    end
    return acc;
  endfunction

  //////////////////////////////
  // S-boxes

  function automatic logic [7:0] sbox(input logic [7:0] a);
    logic [7:0] b;
    b = gf_inv(a);
    return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]} ^ {b[3:0], b[7:4]} ^ 8'h63;
  endfunction

  // Undo affine first, then invert
  function automatic logic [7:0] inv_sbox(input logic [7:0] a);
    logic [7:0] y;
    y = {a[6:0], a[7]} ^ {a[4:0], a[7:5]} ^ {a[1:0], a[7:2]} ^ 8'h05;
    return gf_inv(y);
  endfunction

  // Inverse MixColumns on one column, byte 0 in [31:24]
  function automatic logic [31:0] inv_mix_col(input logic [31:0] col);
    logic [7:0] s0, s1, s2, s3;
    logic [7:0] r0, r1, r2, r3;
    s0 = col[31:24];
    s1 = col[23:16];
    s2 = col[15:8];
    s3 = col[7:0];
    r0 = gf_mul(s0, 8'h0e) ^ gf_mul(s1, 8'h0b) ^ gf_mul(s2, 8'h0d) ^ gf_mul(s3, 8'h09);
    r1 = gf_mul(s0, 8'h09) ^ gf_mul(s1, 8'h0e) ^ gf_mul(s2, 8'h0b) ^ gf_mul(s3, 8'h0d);
    r2 = gf_mul(s0, 8'h0d) ^ gf_mul(s1, 8'h09) ^ gf_mul(s2, 8'h0e) ^ gf_mul(s3, 8'h0b);
    r3 = gf_mul(s0, 8'h0b) ^ gf_mul(s1, 8'h0d) ^ gf_mul(s2, 8'h09) ^ gf_mul(s3, 8'h0e);
    return {r0, r1, r2, r3};
  endfunction

  // Round constant, rounds 1..10
  function automatic logic [7:0] rcon(input logic [ROUND_W-1:0] r);
    case (r)
      4'd1:    return 8'h01;
      4'd2:    return 8'h02;
      4'd3:    return 8'h04;
      4'd4:    return 8'h08;
      4'd5:    return 8'h10;
      4'd6:    return 8'h20;
      4'd7:    return 8'h40;
      4'd8:    return 8'h80;
      4'd9:    return 8'h1b;
      4'd10:   return 8'h36;
      default: return 8'h00;  // Unused round index
    endcase
  endfunction

endpackage
